// File: snake_pkg.sv
`default_nettype none

package snake_pkg;

    typedef logic signed [11:0] coord_t;   // field pixels, origin at screen centre, y up

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } btn_t;

    typedef logic [4:0] length_t;
    typedef logic [5:0] rgb_t;             // rr gg bb
    typedef logic [1:0] speed_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        GAME_OVER
    } game_state_t;

    typedef enum logic [2:0] {
        WAIT,
        RIGHT,
        LEFT,
        UP,
        DOWN
    } heading_t;

    localparam int CELL      = 30;         // one move
    localparam int MAX_LEN   = 20;
    localparam int START_LEN = 5;

    // head dies on or past these
    localparam int WALL_X     = 375;
    localparam int WALL_Y_TOP = 225;
    localparam int WALL_Y_BOT = -275;

    localparam int FOOD_X_LIM = 360;
    localparam int FOOD_Y_TOP = 220;
    localparam int FOOD_Y_BOT = -275;

    localparam int SCREEN_W = 800;
    localparam int SCREEN_H = 600;

    localparam int BODY_R2 = 400;          // squared disc radii
    localparam int FOOD_R2 = 225;

    localparam rgb_t COLOR_SNAKE_A = 6'b001100;
    localparam rgb_t COLOR_SNAKE_B = 6'b111111;
    localparam rgb_t COLOR_FOOD    = 6'b110000;
    localparam rgb_t COLOR_FIELD   = 6'b000000;
    localparam rgb_t COLOR_BORDER  = 6'b111111;

    // move interval in tick units, slowest first
    localparam int SPEED_FACTOR [4] = '{6, 5, 4, 3};

endpackage

`default_nettype wire

// File: move_timer.sv
`timescale 1ns/1ps
`default_nettype none

module move_timer #(
    parameter int unsigned TICK_UNIT = 16_666_667
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_t state,
    input  snake_pkg::heading_t    heading,
    input  logic                   pause,
    input  snake_pkg::speed_t      speed,
    output logic                   move_tick
);

    logic [31:0] count;
    logic [31:0] limit;
    logic        running;

    assign running = (state == snake_pkg::PLAY) && (heading != snake_pkg::WAIT) && !pause;
    assign limit   = TICK_UNIT * 32'(snake_pkg::SPEED_FACTOR[speed]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            count     <= '0;
            move_tick <= 1'b0;
        end else if (!running) begin
            count     <= '0;          // next tick a full interval away
            move_tick <= 1'b0;
        end else if (count >= limit - 1) begin
            count     <= '0;
            move_tick <= 1'b1;
        end else begin
            count     <= count + 1'b1;
            move_tick <= 1'b0;
        end
    end

    // no move ever follows a paused cycle
    assert property (@(posedge CLK) disable iff (RESET) pause |=> !move_tick);

endmodule

`default_nettype wire

// File: game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::btn_t        btn,
    input  logic                   collide,
    output snake_pkg::game_state_t state,
    output snake_pkg::heading_t    heading
);

    logic                any_btn;
    snake_pkg::heading_t heading_nxt;

    assign any_btn = |btn;

    // turns only, a reversal press is ignored
    always_comb begin
        heading_nxt = heading;
        case (heading)
            snake_pkg::WAIT: begin
                if (btn.left || btn.right) begin
                    heading_nxt = snake_pkg::RIGHT;   // first move never runs into the body
                end else if (btn.up) begin
                    heading_nxt = snake_pkg::UP;
                end else if (btn.down) begin
                    heading_nxt = snake_pkg::DOWN;
                end
            end
            snake_pkg::RIGHT, snake_pkg::LEFT: begin
                if (btn.up) begin
                    heading_nxt = snake_pkg::UP;
                end else if (btn.down) begin
                    heading_nxt = snake_pkg::DOWN;
                end
            end
            snake_pkg::UP, snake_pkg::DOWN: begin
                if (btn.left) begin
                    heading_nxt = snake_pkg::LEFT;
                end else if (btn.right) begin
                    heading_nxt = snake_pkg::RIGHT;
                end
            end
            default: heading_nxt = heading;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= snake_pkg::IDLE;
            heading <= snake_pkg::WAIT;
        end else begin
            case (state)
                snake_pkg::IDLE: begin
                    heading <= snake_pkg::WAIT;
                    if (any_btn) begin
                        state <= snake_pkg::PLAY;
                    end
                end
                snake_pkg::PLAY: begin
                    if (collide) begin
                        state <= snake_pkg::GAME_OVER;   // heading frozen from here
                    end else begin
                        heading <= heading_nxt;
                    end
                end
                default: state <= state;             // game over holds until reset
            endcase
        end
    end

    property no_reversal;
        @(posedge CLK) disable iff (RESET)
            (heading == snake_pkg::RIGHT |=> heading != snake_pkg::LEFT) and
            (heading == snake_pkg::LEFT  |=> heading != snake_pkg::RIGHT) and
            (heading == snake_pkg::UP    |=> heading != snake_pkg::DOWN) and
            (heading == snake_pkg::DOWN  |=> heading != snake_pkg::UP);
    endproperty

    assert property (no_reversal);

endmodule

`default_nettype wire

// File: snake_body.sv
`timescale 1ns/1ps
`default_nettype none

module snake_body (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_t state,
    input  snake_pkg::heading_t    heading,
    input  logic                   move_tick,
    input  logic                   eaten,
    output snake_pkg::point_t      body [snake_pkg::MAX_LEN],
    output snake_pkg::length_t     length,
    output logic                   collide
);

    localparam snake_pkg::coord_t STEP = snake_pkg::coord_t'(snake_pkg::CELL);

    snake_pkg::point_t head_nxt;
    logic              hit_wall;
    logic              hit_self;

    // start pose, head four cells right of the origin
    function automatic snake_pkg::point_t start_seg(input int idx);
        snake_pkg::point_t p;
        p.y = '0;
        p.x = (idx < 4) ? snake_pkg::coord_t'((4 - idx) * snake_pkg::CELL) : '0;
        return p;
    endfunction

    always_comb begin
        head_nxt = body[0];
        case (heading)
            snake_pkg::RIGHT: head_nxt.x = body[0].x + STEP;
            snake_pkg::LEFT:  head_nxt.x = body[0].x - STEP;
            snake_pkg::UP:    head_nxt.y = body[0].y + STEP;
            snake_pkg::DOWN:  head_nxt.y = body[0].y - STEP;
            default:          head_nxt   = body[0];
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET || state == snake_pkg::IDLE || heading == snake_pkg::WAIT) begin
            for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
                body[i] <= start_seg(i);
            end
        end else if (move_tick) begin
            body[0] <= head_nxt;
            for (int i = 1; i < snake_pkg::MAX_LEN; i++) begin
                if (i < int'(length)) begin
                    body[i] <= body[i-1];
                end else begin
                    body[i] <= body[4];   // spare slots follow the tail
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= snake_pkg::length_t'(snake_pkg::START_LEN);
        end else if (eaten && int'(length) < snake_pkg::MAX_LEN) begin
            length <= length + 1'b1;
        end
    end

    always_comb begin
        hit_wall = (body[0].x >= snake_pkg::WALL_X) ||
                   (body[0].x <= -snake_pkg::WALL_X) ||
                   (body[0].y >= snake_pkg::WALL_Y_TOP) ||
                   (body[0].y <= snake_pkg::WALL_Y_BOT);
        hit_self = 1'b0;
        for (int i = 1; i < snake_pkg::MAX_LEN; i++) begin
            if (i < int'(length) && body[i] == body[0]) begin
                hit_self = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            collide <= 1'b0;
        end else begin
            collide <= hit_wall || hit_self;
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        int'(length) >= snake_pkg::START_LEN && int'(length) <= snake_pkg::MAX_LEN);

endmodule

`default_nettype wire

// File: food_unit.sv
`timescale 1ns/1ps
`default_nettype none

module food_unit (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_t state,
    input  snake_pkg::point_t      body [snake_pkg::MAX_LEN],
    input  snake_pkg::length_t     length,
    output snake_pkg::point_t      food,
    output logic                   eaten
);

    localparam snake_pkg::point_t PARK    = '{x: 12'sd1000, y: 12'sd1000};   // off the field
    localparam snake_pkg::coord_t RND_LIM = 12'sd500;

    snake_pkg::coord_t rnd;
    snake_pkg::point_t pick_eat;
    snake_pkg::point_t pick_fix;
    logic              out_of_area;
    logic              on_body;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            rnd <= '0;
        end else if (rnd >= RND_LIM) begin
            rnd <= -RND_LIM;
        end else begin
            rnd <= rnd + 1'b1;
        end
    end

    // narrow spread stays in the area, wide one may retry
    assign pick_eat.x = snake_pkg::coord_t'((rnd % 11) * snake_pkg::CELL);
    assign pick_eat.y = snake_pkg::coord_t'((rnd % 8) * snake_pkg::CELL);
    assign pick_fix.x = snake_pkg::coord_t'((rnd % 16) * snake_pkg::CELL);
    assign pick_fix.y = snake_pkg::coord_t'((rnd % 11) * snake_pkg::CELL);

    always_comb begin
        out_of_area = (food.x > snake_pkg::FOOD_X_LIM) || (food.x < -snake_pkg::FOOD_X_LIM) ||
                      (food.y > snake_pkg::FOOD_Y_TOP) || (food.y < snake_pkg::FOOD_Y_BOT);
        on_body = 1'b0;
        for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
            if (i < int'(length) && body[i] == food) begin
                on_body = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            food  <= PARK;
            eaten <= 1'b0;
        end else begin
            eaten <= 1'b0;
            if (state == snake_pkg::IDLE) begin
                food <= PARK;
            end else if (state == snake_pkg::PLAY) begin
                if (body[0] == food) begin
                    eaten <= 1'b1;
                    food  <= pick_eat;
                end else if (out_of_area || on_body) begin
                    food <= pick_fix;        // also leaves the park on the first play cycle
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: pixel_painter.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_painter (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_t state,
    input  snake_pkg::point_t      body [snake_pkg::MAX_LEN],
    input  snake_pkg::length_t     length,
    input  snake_pkg::point_t      food,
    input  logic                   snake_color_sel,
    output snake_pkg::coord_t      pixel_x,
    output snake_pkg::coord_t      pixel_y,
    output logic                   pixel_valid,
    output snake_pkg::rgb_t        color
);

    logic [9:0]        col;
    logic [9:0]        row;
    snake_pkg::coord_t x;
    snake_pkg::coord_t y;
    logic              in_body;
    logic              in_food;
    logic              in_field;
    snake_pkg::rgb_t   color_nxt;

    function automatic int dist2(input snake_pkg::coord_t px, input snake_pkg::coord_t py,
                                 input snake_pkg::point_t c);
        int dx;
        int dy;
        dx = int'(px) - int'(c.x);
        dy = int'(py) - int'(c.y);
        return dx * dx + dy * dy;
    endfunction

    always_ff @(posedge CLK) begin
        if (RESET) begin
            col <= '0;
            row <= '0;
        end else if (col == 10'(snake_pkg::SCREEN_W - 1)) begin
            col <= '0;
            row <= (row == 10'(snake_pkg::SCREEN_H - 1)) ? '0 : row + 1'b1;
        end else begin
            col <= col + 1'b1;
        end
    end

    assign x = snake_pkg::coord_t'(int'(col) - snake_pkg::SCREEN_W / 2);
    assign y = snake_pkg::coord_t'(snake_pkg::SCREEN_H / 2 - int'(row));   // y grows up

    always_comb begin
        in_body = 1'b0;
        for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
            if (i < int'(length) && dist2(x, y, body[i]) < snake_pkg::BODY_R2) begin
                in_body = 1'b1;
            end
        end
        in_food  = dist2(x, y, food) < snake_pkg::FOOD_R2;
        in_field = (x > -snake_pkg::WALL_X) && (x < snake_pkg::WALL_X) &&
                   (y > snake_pkg::WALL_Y_BOT) && (y < snake_pkg::FOOD_Y_TOP);
        if (in_body) begin
            color_nxt = snake_color_sel ? snake_pkg::COLOR_SNAKE_B : snake_pkg::COLOR_SNAKE_A;
        end else if (in_food) begin
            color_nxt = snake_pkg::COLOR_FOOD;
        end else if (in_field) begin
            color_nxt = snake_pkg::COLOR_FIELD;
        end else begin
            color_nxt = snake_pkg::COLOR_BORDER;
        end
    end

    always_ff @(posedge CLK) begin
        pixel_x <= x;
        pixel_y <= y;
        color   <= color_nxt;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pixel_valid <= 1'b0;
        end else begin
            pixel_valid <= (state == snake_pkg::PLAY);
        end
    end

endmodule

`default_nettype wire

// File: snake_game.sv
`timescale 1ns/1ps
`default_nettype none

module snake_game #(
    parameter int unsigned TICK_UNIT = 16_666_667   // cycles per speed factor step
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::btn_t        btn,
    input  logic                   pause,
    input  snake_pkg::speed_t      speed,
    input  logic                   snake_color_sel,
    output snake_pkg::game_state_t state,
    output snake_pkg::point_t      head,
    output snake_pkg::length_t     length,
    output snake_pkg::point_t      food,
    output snake_pkg::coord_t      pixel_x,
    output snake_pkg::coord_t      pixel_y,
    output logic                   pixel_valid,
    output snake_pkg::rgb_t        color
);

    snake_pkg::heading_t heading;
    logic                move_tick;
    logic                collide;
    logic                eaten;
    snake_pkg::point_t   body [snake_pkg::MAX_LEN];

    assign head = body[0];

    game_fsm u_fsm (
        .CLK     (CLK),
        .RESET   (RESET),
        .btn     (btn),
        .collide (collide),
        .state   (state),
        .heading (heading)
    );

    move_timer #(.TICK_UNIT(TICK_UNIT)) u_timer (
        .CLK       (CLK),
        .RESET     (RESET),
        .state     (state),
        .heading   (heading),
        .pause     (pause),
        .speed     (speed),
        .move_tick (move_tick)
    );

    snake_body u_body (
        .CLK       (CLK),
        .RESET     (RESET),
        .state     (state),
        .heading   (heading),
        .move_tick (move_tick),
        .eaten     (eaten),
        .body      (body),
        .length    (length),
        .collide   (collide)
    );

    food_unit u_food (
        .CLK    (CLK),
        .RESET  (RESET),
        .state  (state),
        .body   (body),
        .length (length),
        .food   (food),
        .eaten  (eaten)
    );

    pixel_painter u_paint (
        .CLK             (CLK),
        .RESET           (RESET),
        .state           (state),
        .body            (body),
        .length          (length),
        .food            (food),
        .snake_color_sel (snake_color_sel),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .pixel_valid     (pixel_valid),
        .color           (color)
    );

endmodule

`default_nettype wire

// File: tb_snake_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snake_game;

    localparam int TICK     = 4;
    localparam int NROWS    = 10;
    localparam int EAT_MAX  = 80;
    localparam int FRAME    = 800 * 600;
    localparam int MOVE_TMO = 400;
    localparam int SPD [4]  = '{6, 5, 4, 3};          // cycles per move in tick units
    localparam int DX [4]   = '{30, -30, 0, 0};       // right, left, up, down
    localparam int DY [4]   = '{0, 0, 30, -30};
    localparam logic [3:0] BTN_OF [4] = '{4'b0100, 4'b1000, 4'b0010, 4'b0001};

    typedef struct packed {
        logic [3:0] btn;      // left, right, up, down
        logic       pause;
        logic [1:0] speed;
        logic       sel;
        int         moves;
        int         hold;
        logic       scan;
        int         x;
        int         y;
        logic [1:0] st;       // 1 play, 2 game over
    } row_t;

    localparam row_t ROWS [NROWS] = '{
        '{4'b0100, 1'b0, 2'd0, 1'b0, 3, 0,   1'b0, 210, 0,   2'd1},
        '{4'b1000, 1'b0, 2'd0, 1'b0, 2, 0,   1'b0, 270, 0,   2'd1},   // reversal ignored
        '{4'b0010, 1'b0, 2'd0, 1'b0, 2, 0,   1'b0, 270, 60,  2'd1},
        '{4'b0000, 1'b0, 2'd1, 1'b0, 2, 0,   1'b0, 270, 120, 2'd1},
        '{4'b1000, 1'b0, 2'd2, 1'b0, 2, 0,   1'b0, 210, 120, 2'd1},
        '{4'b0001, 1'b0, 2'd3, 1'b0, 5, 0,   1'b0, 210, -30, 2'd1},
        '{4'b0000, 1'b1, 2'd3, 1'b1, 0, 100, 1'b1, 210, -30, 2'd1},   // paused frame scan
        '{4'b0000, 1'b1, 2'd3, 1'b0, 0, 0,   1'b1, 210, -30, 2'd1},   // green snake
        '{4'b0100, 1'b0, 2'd0, 1'b0, 6, 0,   1'b0, 390, -30, 2'd2},   // into the wall
        '{4'b0010, 1'b0, 2'd0, 1'b0, 0, 100, 1'b0, 390, -30, 2'd2}
    };

    logic                   CLK;
    logic                   RESET;
    snake_pkg::btn_t        btn;
    logic                   pause;
    snake_pkg::speed_t      speed;
    logic                   sel;
    snake_pkg::game_state_t state;
    snake_pkg::point_t      head;
    snake_pkg::length_t     length;
    snake_pkg::point_t      food;
    snake_pkg::coord_t      pixel_x;
    snake_pkg::coord_t      pixel_y;
    logic                   pixel_valid;
    snake_pkg::rgb_t        color;

    snake_pkg::point_t hist [$];   // head positions, oldest first
    int                exp_len;
    int                n_err;
    int                n_tests;
    int                n_bad;
    int                cycles;
    int                limit;
    logic [31:0]       rng;

    snake_game #(.TICK_UNIT(TICK)) uut (
        .CLK             (CLK),
        .RESET           (RESET),
        .btn             (btn),
        .pause           (pause),
        .speed           (speed),
        .snake_color_sel (sel),
        .state           (state),
        .head            (head),
        .length          (length),
        .food            (food),
        .pixel_x         (pixel_x),
        .pixel_y         (pixel_y),
        .pixel_valid     (pixel_valid),
        .color           (color)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // head meeting food in play means one more segment
    always @(negedge CLK) begin
        if (RESET) begin
            exp_len = 5;
        end else if (state == snake_pkg::PLAY && head == food && exp_len < 20) begin
            exp_len = exp_len + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int dist2(input int px, input int py, input int cx, input int cy);
        return (px - cx) * (px - cx) + (py - cy) * (py - cy);
    endfunction

    // any recent head position close enough to be drawn
    function automatic logic near_body(input int px, input int py);
        logic hit;
        int   n;
        hit = 1'b0;
        n   = hist.size();
        for (int i = 0; i < 21 && i < n; i++) begin
            if (dist2(px, py, int'(hist[n-1-i].x), int'(hist[n-1-i].y)) < 400) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic logic safe_cell(input int x, input int y);
        logic ok;
        int   n;
        ok = (x >= -360) && (x <= 360) && (y >= -270) && (y <= 210);
        n  = hist.size();
        for (int i = 0; i <= exp_len && i < n; i++) begin
            if (int'(hist[n-1-i].x) == x && int'(hist[n-1-i].y) == y) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // greedy step toward the food that avoids reversal, walls and body
    function automatic int pick_dir(input int cur);
        int cand [6];
        int hx;
        int hy;
        int fx;
        int fy;
        hx = int'(head.x);
        hy = int'(head.y);
        fx = int'(food.x);
        fy = int'(food.y);
        cand[0] = (fx > hx) ? 0 : 1;
        cand[1] = (fy > hy) ? 2 : 3;
        if (fx == hx) begin
            cand[0] = cand[1];
        end
        if (fy == hy) begin
            cand[1] = cand[0];
        end
        for (int i = 2; i < 6; i++) begin
            cand[i] = i - 2;
        end
        for (int i = 0; i < 6; i++) begin
            if (cand[i] != (cur ^ 1) && safe_cell(hx + DX[cand[i]], hy + DY[cand[i]])) begin
                return cand[i];
            end
        end
        return cur;
    endfunction

    task automatic report_mismatch(input string name, input int got, input int exp);
        n_err++;
        $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
    endtask

    task automatic finish_test(input string name, input int e0);
        n_tests++;
        if (n_err == e0) begin
            $display("test %s: ok", name);
        end else begin
            n_bad++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic reset_dut();
        snake_pkg::point_t p;
        @(posedge CLK);
        RESET <= 1'b1;
        btn   <= '0;
        pause <= 1'b0;
        speed <= '0;
        sel   <= 1'b0;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
        hist.delete();
        for (int i = 0; i < 5; i++) begin
            p.x = snake_pkg::coord_t'(30 * i);
            p.y = '0;
            hist.push_back(p);
        end
        @(negedge CLK);
    endtask

    // cycles until the head changes, counted on falling edges
    task automatic wait_move(output int cyc);
        snake_pkg::point_t prev;
        prev = head;
        cyc  = 0;
        while (head == prev && cyc < MOVE_TMO) begin
            @(negedge CLK);
            cyc++;
        end
        if (head == prev) begin
            n_err++;
            $display("head did not move within %0d cycles", MOVE_TMO);
        end else begin
            hist.push_back(head);
        end
    endtask

    task automatic scan_frame();
        int              px;
        int              py;
        int              nx;
        int              ny;
        logic            seen;
        logic            found;
        logic            skip;
        int              shown;
        snake_pkg::rgb_t want;
        found = 1'b0;
        seen  = 1'b0;
        nx    = 0;
        ny    = 0;
        shown = 0;
        repeat (FRAME + 4) begin
            @(negedge CLK);
            px   = int'(pixel_x);
            py   = int'(pixel_y);
            skip = 1'b0;
            want = 6'b111111;
            if (seen && (px != nx || py != ny)) begin
                n_err++;
                if (shown < 5) begin
                    $display("[FAIL] pixel_x/pixel_y: got 0x%0h/0x%0h expected 0x%0h/0x%0h",
                             pixel_x, pixel_y, snake_pkg::coord_t'(nx),
                             snake_pkg::coord_t'(ny));
                end
                shown++;
            end
            seen = 1'b1;
            // row-major raster, y counts down
            nx = (px == 399) ? -400 : px + 1;
            ny = (px != 399) ? py : ((py == -299) ? 300 : py - 1);
            if (!pixel_valid) begin
                skip = 1'b1;
            end else if (px == int'(head.x) && py == int'(head.y)) begin
                want  = sel ? 6'b111111 : 6'b001100;
                found = 1'b1;
            end else if (px == int'(food.x) && py == int'(food.y) && !near_body(px, py)) begin
                want = 6'b110000;
            end else if (near_body(px, py) ||
                         dist2(px, py, int'(food.x), int'(food.y)) < 225) begin
                skip = 1'b1;   // disc edges
            end else if (px > -375 && px < 375 && py > -275 && py < 220) begin
                want = 6'b000000;
            end
            if (!skip && color != want) begin
                n_err++;
                if (shown < 5) begin
                    $display("[FAIL] color at (%0d,%0d): got 0x%0h expected 0x%0h",
                             px, py, color, want);
                end
                shown++;
            end
        end
        if (!found) begin
            n_err++;
            $display("the head pixel never showed up in the scan");
        end
    endtask

    task automatic run_eat_test();
        int                cur;
        int                cyc;
        int                e0;
        logic              done;
        snake_pkg::point_t f_before;
        snake_pkg::point_t f0;
        e0   = n_err;
        cur  = 0;
        done = 1'b0;
        f0   = food;
        reset_dut();
        @(posedge CLK);
        btn <= BTN_OF[0];
        for (int i = 0; i < EAT_MAX && !done; i++) begin
            f_before = food;
            wait_move(cyc);
            if (head == food || int'(length) != 5) begin
                f0   = (head == food) ? food : f_before;
                done = 1'b1;
            end else begin
                cur = pick_dir(cur);
                @(posedge CLK);
                btn <= BTN_OF[cur];
            end
        end
        if (!done) begin
            n_err++;
            $display("head never reached the food in %0d moves", EAT_MAX);
        end else begin
            repeat (3) @(negedge CLK);
            if (int'(length) != 6) report_mismatch("length", int'(length), 6);
            if (food == f0) begin
                n_err++;
                $display("food stayed in place after it was eaten");
            end
            if (int'(food.x) % 30 != 0 || int'(food.y) % 30 != 0 ||
                int'(food.x) > 360 || int'(food.x) < -360 ||
                int'(food.y) > 220 || int'(food.y) < -275) begin
                n_err++;
                $display("new food (%0d,%0d) is off the grid or outside the food area",
                         int'(food.x), int'(food.y));
            end
        end
        finish_test("eating", e0);
    endtask

    initial begin
        int cyc;
        int e0;
        int total;
        RESET   = 1'b1;
        btn     = '0;
        pause   = 1'b0;
        speed   = '0;
        sel     = 1'b0;
        cycles  = 0;
        n_err   = 0;
        n_tests = 0;
        n_bad   = 0;
        rng     = 32'd58613;
        total   = EAT_MAX;
        for (int r = 0; r < NROWS; r++) begin
            total += ROWS[r].moves;
        end
        limit = total * 6 * TICK * 2 + 2 * FRAME + 20000;

        e0 = n_err;
        reset_dut();
        if (state != snake_pkg::IDLE) report_mismatch("state", int'(state), 0);
        if (int'(head.x) != 120) report_mismatch("head.x", int'(head.x), 120);
        if (int'(head.y) != 0) report_mismatch("head.y", int'(head.y), 0);
        if (int'(length) != 5) report_mismatch("length", int'(length), 5);
        if (int'(food.x) != 1000) report_mismatch("food.x", int'(food.x), 1000);
        if (int'(food.y) != 1000) report_mismatch("food.y", int'(food.y), 1000);
        if (pixel_valid !== 1'b0) report_mismatch("pixel_valid", int'(pixel_valid), 0);
        finish_test("reset", e0);

        for (int r = 0; r < NROWS; r++) begin
            e0  = n_err;
            rng = xorshift32(rng);
            repeat (rng % 8) @(posedge CLK);
            @(posedge CLK);
            btn   <= ROWS[r].btn;
            pause <= ROWS[r].pause;
            speed <= ROWS[r].speed;
            sel   <= ROWS[r].sel;
            for (int m = 0; m < ROWS[r].moves; m++) begin
                wait_move(cyc);
                // the first interval straddles the row change
                if (m > 0 && cyc != TICK * SPD[ROWS[r].speed]) begin
                    report_mismatch("move interval", cyc, TICK * SPD[ROWS[r].speed]);
                end
            end
            repeat (ROWS[r].hold) @(negedge CLK);
            if (ROWS[r].scan) begin
                scan_frame();
            end
            for (int w = 0; w < 20 && ROWS[r].st == 2'd2 && state != snake_pkg::GAME_OVER;
                 w++) begin
                @(negedge CLK);
            end
            repeat (3) @(negedge CLK);
            if (int'(head.x) != ROWS[r].x) report_mismatch("head.x", int'(head.x), ROWS[r].x);
            if (int'(head.y) != ROWS[r].y) report_mismatch("head.y", int'(head.y), ROWS[r].y);
            if (int'(state) != int'(ROWS[r].st)) begin
                report_mismatch("state", int'(state), int'(ROWS[r].st));
            end
            if (int'(length) != exp_len) report_mismatch("length", int'(length), exp_len);
            finish_test($sformatf("row %0d", r), e0);
        end

        run_eat_test();

        $display("summary: %0d tests, %0d failed, %0d check errors", n_tests, n_bad, n_err);
        if (n_err == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
snake_pkg.sv
move_timer.sv
game_fsm.sv
snake_body.sv
food_unit.sv
pixel_painter.sv
snake_game.sv
tb_snake_game.sv

// File: run.sh
#!/bin/sh
# build and run the snake game testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_snake_game -o sim_snake
./obj_dir/sim_snake > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
grep -q "TESTS PASSED" sim.log
